// File: Bender.yml
package:
  name: reg_main

sources:
  - include_dirs:
      - .
    files:
      - main_reg_pkg.sv
      - fifo_word_pkg.sv
      - reg_decode.sv
      - config_regs.sv
      - read_path.sv
      - reg_main_top.sv
      - target: test
        include_dirs:
          - .
        files:
          - reg_main_checker.sv
          - reg_main_assert.sv
          - tb_reg_main.sv

// File: config_regs.sv
// Configuration registers, arm and capture-now control and their read-back byte
`timescale 1ns/1ps
`include "main_reg_params.svh"

module config_regs
   import main_reg_pkg::*;
(
   input  logic                          cwusb_clk,
   input  logic                          fpga_reset,
   input  logic                          sel_write,
   input  reg_addr_e                     reg_index,
   input  logic [`MAIN_BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic [7:0]                    write_data,
   input  logic                          capture_enable_pulse,
   input  logic                          flushing,
   output logic                          arm,
   output logic                          reg_arm,
   output logic                          arm_pulse,
   output logic                          capture_now,
   output logic                          trigger_enable,
   output trig_time_t                    trigger_delay,
   output trig_time_t                    trigger_width,
   output num_trig_t                     num_triggers,
   output capture_len_t                  capture_len,
   output logic [7:0]                    cfg_rdata
);

   // Byte lanes in a multi-byte field
   localparam int FIELD_BYTES = `TRIG_TIME_WIDTH / 8;

   logic reg_arm_r;
   logic cap_req;
   logic cap_req_r;
   logic arm_wr;

   // Replace one byte lane, out of range lanes leave the field alone
   function automatic trig_time_t lane_write(input trig_time_t cur,
                                             input logic [`MAIN_BYTECNT_WIDTH-1:0] lane,
                                             input logic [7:0] data);
      trig_time_t res;
      res = cur;
      if (lane < FIELD_BYTES)
         res[lane*8 +: 8] = data;
      return res;
   endfunction

   function automatic logic [7:0] lane_read(input trig_time_t cur,
                                            input logic [`MAIN_BYTECNT_WIDTH-1:0] lane);
      logic [7:0] res;
      res = 8'h00;
      if (lane < FIELD_BYTES)
         res = cur[lane*8 +: 8];
      return res;
   endfunction

   assign arm_wr = sel_write && (reg_index == REG_ARM);

   ///////////////////////////////
   // Field writes
   ///////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         trigger_enable <= 1'b0;
         trigger_delay  <= '0;
         trigger_width  <= '0;
         num_triggers   <= num_trig_t'(`NUM_TRIG_RESET);
         capture_len    <= '0;
      end else if (sel_write) begin
         case (reg_index)
            REG_TRIGGER_ENABLE: trigger_enable <= write_data[0];
            REG_TRIGGER_DELAY:  trigger_delay <= lane_write(trigger_delay, reg_bytecnt, write_data);
            REG_TRIGGER_WIDTH:  trigger_width <= lane_write(trigger_width, reg_bytecnt, write_data);
            REG_NUM_TRIGGERS:   num_triggers <= write_data[`NUM_TRIG_WIDTH-1:0];
            REG_CAPTURE_LEN:    capture_len <= lane_write(capture_len, reg_bytecnt, write_data);
            default: ;
         endcase
      end
   end

   ///////////////////////////////
   // Arm control
   ///////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_arm   <= 1'b0;
         reg_arm_r <= 1'b0;
         arm_pulse <= 1'b0;
         cap_req   <= 1'b0;
         cap_req_r <= 1'b0;
      end else begin
         // Arming write wins over a capture start in the same cycle
         if (arm_wr && write_data[0])
            reg_arm <= 1'b1;
         else if (capture_enable_pulse)
            reg_arm <= 1'b0;
         reg_arm_r <= reg_arm;
         arm_pulse <= reg_arm && !reg_arm_r;
         cap_req   <= arm_wr && write_data[1];
         cap_req_r <= cap_req;
      end
   end

   // Held off while the front end drains
   assign arm = reg_arm_r && !flushing;

   assign capture_now = cap_req && !cap_req_r;

   // Read-back byte
   always_comb begin
      case (reg_index)
         REG_ARM:            cfg_rdata = {7'b0, reg_arm};
         REG_TRIGGER_ENABLE: cfg_rdata = {7'b0, trigger_enable};
         REG_TRIGGER_DELAY:  cfg_rdata = lane_read(trigger_delay, reg_bytecnt);
         REG_TRIGGER_WIDTH:  cfg_rdata = lane_read(trigger_width, reg_bytecnt);
         REG_NUM_TRIGGERS:   cfg_rdata = {{(8-`NUM_TRIG_WIDTH){1'b0}}, num_triggers};
         REG_CAPTURE_LEN:    cfg_rdata = lane_read(capture_len, reg_bytecnt);
         default:            cfg_rdata = 8'h00;
      endcase
   end

endmodule

// File: fifo_word_pkg.sv
// Sniff FIFO word and status types and front-end FIFO command enum
`include "main_reg_params.svh"

package fifo_word_pkg;

   typedef logic [`FIFO_WORD_WIDTH-1:0] fifo_word_t;

   typedef logic [`FIFO_STATUS_WIDTH-1:0] fifo_status_t;

   // Command in word bits 17:16
   typedef enum logic [1:0] {
      FIFO_CMD_DATA = 2'b00,
      FIFO_CMD_TIME = 2'b01,
      FIFO_CMD_STRM = `FIFO_CMD_STRM,
      FIFO_CMD_STAT = 2'b11
   } fifo_cmd_e;

endpackage

// File: filelist.f
+incdir+.
main_reg_pkg.sv
fifo_word_pkg.sv
reg_decode.sv
config_regs.sv
read_path.sv
reg_main_top.sv
reg_main_checker.sv
reg_main_assert.sv
tb_reg_main.sv

// File: main_reg_params.svh
// Block select code, field widths, reset values and stream marker codes
`ifndef MAIN_REG_PARAMS_SVH
`define MAIN_REG_PARAMS_SVH

// Address bits 7:6 that select the main register block
`define MAIN_REG_SELECT 2'b00

`define MAIN_BYTECNT_WIDTH 7

// Trigger and capture fields
`define TRIG_TIME_WIDTH 24
`define CAPTURE_LEN_WIDTH 24
`define NUM_TRIG_WIDTH 4
`define NUM_TRIG_RESET 1

// Sniff FIFO word layout
`define FIFO_WORD_WIDTH 18
`define FIFO_STATUS_WIDTH 6
`define FIFO_STRM_EMPTY 8'h02
`define FIFO_CMD_STRM 2'b10

`endif

// File: main_reg_pkg.sv
// Register map enum and configuration field types of the main register block
`include "main_reg_params.svh"

package main_reg_pkg;

   ///////////////////////////////
   // Register map
   ///////////////////////////////

   // Index in address bits 5:0
   typedef enum logic [5:0] {
      REG_FIFO_STAT      = 6'h03,
      REG_FIFO_RD        = 6'h04,
      REG_ARM            = 6'h05,
      REG_TRIGGER_ENABLE = 6'h07,
      REG_NUM_TRIGGERS   = 6'h08,
      REG_TRIGGER_DELAY  = 6'h09,
      REG_TRIGGER_WIDTH  = 6'h0a,
      REG_CAPTURE_LEN    = 6'h14
   } reg_addr_e;

   ///////////////////////////////
   // Configuration fields
   ///////////////////////////////

   typedef logic [`TRIG_TIME_WIDTH-1:0] trig_time_t;

   typedef logic [`CAPTURE_LEN_WIDTH-1:0] capture_len_t;

   typedef logic [`NUM_TRIG_WIDTH-1:0] num_trig_t;

endpackage

// File: read_path.sv
// Read side: sniff FIFO read strobe, empty-read marker, byte select and read data register
`timescale 1ns/1ps
`include "main_reg_params.svh"

module read_path
   import main_reg_pkg::*;
   import fifo_word_pkg::*;
(
   input  logic                          cwusb_clk,
   input  logic                          fpga_reset,
   input  logic                          sel_read,
   input  logic                          first_read,
   input  reg_addr_e                     reg_index,
   input  logic [`MAIN_BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic [7:0]                    cfg_rdata,
   input  fifo_word_t                    fifo_data,
   input  fifo_status_t                  fifo_status,
   input  logic                          fifo_empty,
   output logic                          fifo_read,
   output logic [7:0]                    read_data
);

   // Word returned while the stream has run dry
   localparam fifo_word_t STRM_EMPTY_WORD = {FIFO_CMD_STRM,
                                             {(`FIFO_WORD_WIDTH-10){1'b0}},
                                             `FIFO_STRM_EMPTY};

   logic         fifo_empty_r;
   logic         empty_read;
   fifo_word_t   fifo_word_r;
   fifo_word_t   word_sel;
   logic [1:0]   lane;
   logic         fifo_access;
   logic [7:0]   rdata_pre;
   logic [7:0]   status_byte;

   // FIFO register repeats every four bytes
   assign lane        = reg_bytecnt[1:0];
   assign fifo_access = sel_read && (reg_index == REG_FIFO_RD);
   assign status_byte = {{(8-`FIFO_STATUS_WIDTH){1'b0}}, fifo_status};

   ///////////////////////////////
   // FIFO pop and empty flag
   ///////////////////////////////

   // Pop on the first byte of a word burst
   assign fifo_read = first_read && (reg_index == REG_FIFO_RD) && (lane == 2'd0) &&
                      !fifo_empty_r && !empty_read;

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         fifo_empty_r <= 1'b0;
         empty_read   <= 1'b0;
      end else begin
         fifo_empty_r <= fifo_empty;
         if (first_read && (reg_index == REG_FIFO_RD) && (lane == 2'd0) && fifo_empty_r)
            empty_read <= 1'b1;
         else if (fifo_access && (lane == 2'd3) && !fifo_empty_r)
            empty_read <= 1'b0;
      end
   end

   // Word held for the rest of the burst
   always_ff @(posedge cwusb_clk) begin
      if (fifo_read)
         fifo_word_r <= fifo_data;
   end

   assign word_sel = empty_read ? STRM_EMPTY_WORD : fifo_word_r;

   ///////////////////////////////
   // Byte select
   ///////////////////////////////

   always_comb begin
      rdata_pre = 8'h00;
      if (sel_read) begin
         case (reg_index)
            REG_FIFO_STAT: rdata_pre = status_byte;
            REG_FIFO_RD: begin
               case (lane)
                  2'd1:    rdata_pre = word_sel[7:0];
                  2'd2:    rdata_pre = word_sel[15:8];
                  2'd3:    rdata_pre = {fifo_status, word_sel[17:16]};
                  default: rdata_pre = 8'h00;
               endcase
            end
            default: rdata_pre = cfg_rdata;
         endcase
      end
   end

   // One cycle of read latency on the bus
   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         read_data <= 8'h00;
      end else begin
         read_data <= rdata_pre;
      end
   end

endmodule

// File: reg_decode.sv
// Register bus decode: block select, register index and read burst start
`timescale 1ns/1ps
`include "main_reg_params.svh"

module reg_decode
   import main_reg_pkg::*;
(
   input  logic       cwusb_clk,
   input  logic       fpga_reset,
   input  logic [7:0] reg_address,
   input  logic       reg_addrvalid,
   input  logic       reg_read,
   input  logic       reg_write,
   output logic       sel_read,
   output logic       sel_write,
   output logic       first_read,
   output reg_addr_e  reg_index
);

   logic selected;
   logic reg_read_r;

   // Block hit on the upper address bits
   assign selected = reg_addrvalid && (reg_address[7:6] == `MAIN_REG_SELECT);

   assign sel_read  = selected && reg_read;
   assign sel_write = selected && reg_write;

   // Start of a read burst
   assign first_read = sel_read && !reg_read_r;

   assign reg_index = reg_addr_e'(reg_address[5:0]);

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_read_r <= 1'b0;
      end else begin
         reg_read_r <= reg_read;
      end
   end

endmodule

// File: reg_main_assert.sv
// Concurrent assertions on the FIFO read strobe and the arm and capture pulses, bound to the top
`timescale 1ns/1ps

module reg_main_assert (
   input logic cwusb_clk,
   input logic fpga_reset,
   input logic fifo_read,
   input logic fifo_empty,
   input logic arm_pulse,
   input logic capture_now
);

   int failures = 0;

   fifo_read_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      fifo_read |=> !fifo_read)
      else begin
         $error("fifo_read stayed high for two cycles");
         failures++;
      end

   arm_pulse_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      arm_pulse |=> !arm_pulse)
      else begin
         $error("arm_pulse stayed high for two cycles");
         failures++;
      end

   capture_now_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      capture_now |=> !capture_now)
      else begin
         $error("capture_now stayed high for two cycles");
         failures++;
      end

   // No pop when the FIFO reported empty on the previous edge
   no_read_when_empty: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      fifo_read |-> !$past(fifo_empty))
      else begin
         $error("fifo_read asserted while the FIFO was empty");
         failures++;
      end

endmodule

bind reg_main_top reg_main_assert assert_i (
   .cwusb_clk   (cwusb_clk),
   .fpga_reset  (fpga_reset),
   .fifo_read   (fifo_read),
   .fifo_empty  (fifo_empty),
   .arm_pulse   (arm_pulse),
   .capture_now (capture_now)
);

// File: reg_main_checker.sv
// Register map and sniff FIFO reference model, compares DUT outputs on every clock edge
`timescale 1ns/1ps
`include "main_reg_params.svh"

module reg_main_checker
   import main_reg_pkg::*;
   import fifo_word_pkg::*;
(
   input  logic                           cwusb_clk,
   input  logic                           fpga_reset,
   input  logic [7:0]                     reg_address,
   input  logic [`MAIN_BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic                           reg_addrvalid,
   input  logic                           reg_read,
   input  logic                           reg_write,
   input  logic [7:0]                     write_data,
   input  logic [7:0]                     read_data,
   input  fifo_word_t                     fifo_data,
   input  fifo_status_t                   fifo_status,
   input  logic                           fifo_empty,
   input  logic                           fifo_read,
   input  logic                           capture_enable_pulse,
   input  logic                           flushing,
   input  logic                           arm,
   input  logic                           reg_arm,
   input  logic                           arm_pulse,
   input  logic                           capture_now,
   input  capture_len_t                   capture_len,
   input  logic                           trigger_enable,
   input  trig_time_t                     trigger_delay,
   input  trig_time_t                     trigger_width,
   input  num_trig_t                      num_triggers,
   input  logic [127:0]                   test_name,
   output int                             checks,
   output int                             value_errors
);

   // Stream command on top, empty code in the low byte
   localparam fifo_word_t EMPTY_MARKER = {`FIFO_CMD_STRM, 8'h00, `FIFO_STRM_EMPTY};

   // Model state mirroring the visible register contents
   logic         m_en;
   trig_time_t   m_delay;
   trig_time_t   m_width;
   num_trig_t    m_num;
   capture_len_t m_len;
   logic         m_arm;
   logic         m_arm_r;
   logic         m_pulse;
   logic         m_cap;
   logic         m_cap_r;
   logic         m_rd_prev;
   logic         m_empty_r;
   logic         m_empty_rd;
   fifo_word_t   m_word;
   logic [7:0]   m_rdata;

   // Per-edge decode
   logic       sel;
   logic       first;
   logic       pop;
   logic       arm_wr;
   logic       next_arm;
   logic [5:0] idx;
   logic [6:0] lane;

   initial begin
      checks       = 0;
      value_errors = 0;
   end

   task automatic check_val(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         value_errors++;
         $display("** Error [%0s] %0s: expected %0h, actual %0h",
                  test_name, what, expected, actual);
      end
   endtask

   function automatic logic [7:0] field_byte(input logic [23:0] f, input logic [6:0] ln);
      if (ln < 3)
         return f[ln*8 +: 8];
      return 8'h00;
   endfunction

   ///////////////////////////////
   // Expected read byte
   ///////////////////////////////

   function automatic logic [7:0] expect_byte(input logic [5:0] ix, input logic [6:0] ln);
      fifo_word_t w;
      w = m_empty_rd ? EMPTY_MARKER : m_word;
      case (ix)
         REG_FIFO_STAT:      return {2'b00, fifo_status};
         REG_FIFO_RD: begin
            case (ln[1:0])
               2'd1:    return w[7:0];
               2'd2:    return w[15:8];
               2'd3:    return {fifo_status, w[17:16]};
               default: return 8'h00;
            endcase
         end
         REG_ARM:            return {7'b0, m_arm};
         REG_TRIGGER_ENABLE: return {7'b0, m_en};
         REG_NUM_TRIGGERS:   return {4'b0, m_num};
         REG_TRIGGER_DELAY:  return field_byte(m_delay, ln);
         REG_TRIGGER_WIDTH:  return field_byte(m_width, ln);
         REG_CAPTURE_LEN:    return field_byte(m_len, ln);
         default:            return 8'h00;
      endcase
   endfunction

   ///////////////////////////////
   // Compare, then step the model
   ///////////////////////////////

   always @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         m_en       = 1'b0;
         m_delay    = '0;
         m_width    = '0;
         m_num      = num_trig_t'(`NUM_TRIG_RESET);
         m_len      = '0;
         m_arm      = 1'b0;
         m_arm_r    = 1'b0;
         m_pulse    = 1'b0;
         m_cap      = 1'b0;
         m_cap_r    = 1'b0;
         m_rd_prev  = 1'b0;
         m_empty_r  = 1'b0;
         m_empty_rd = 1'b0;
         m_rdata    = 8'h00;
      end else begin
         sel    = reg_addrvalid && (reg_address[7:6] == `MAIN_REG_SELECT);
         idx    = reg_address[5:0];
         lane   = reg_bytecnt;
         first  = sel && reg_read && !m_rd_prev;
         pop    = first && (idx == REG_FIFO_RD) && (lane[1:0] == 2'd0) &&
                  !m_empty_r && !m_empty_rd;
         arm_wr = sel && reg_write && (idx == REG_ARM);

         check_val("read_data", m_rdata, read_data);
         check_val("fifo_read", pop, fifo_read);
         check_val("reg_arm", m_arm, reg_arm);
         check_val("arm", m_arm_r && !flushing, arm);
         check_val("arm_pulse", m_pulse, arm_pulse);
         check_val("capture_now", m_cap && !m_cap_r, capture_now);
         check_val("trigger_enable", m_en, trigger_enable);
         check_val("trigger_delay", m_delay, trigger_delay);
         check_val("trigger_width", m_width, trigger_width);
         check_val("num_triggers", m_num, num_triggers);
         check_val("capture_len", m_len, capture_len);

         // Read byte uses the state before this edge
         m_rdata = (sel && reg_read) ? expect_byte(idx, lane) : 8'h00;

         if (first && (idx == REG_FIFO_RD) && (lane[1:0] == 2'd0) && m_empty_r)
            m_empty_rd = 1'b1;
         else if (sel && reg_read && (idx == REG_FIFO_RD) && (lane[1:0] == 2'd3) && !m_empty_r)
            m_empty_rd = 1'b0;
         m_empty_r = fifo_empty;
         m_rd_prev = reg_read;
         if (pop)
            m_word = fifo_data;

         // Arming write beats a capture start
         next_arm = (arm_wr && write_data[0]) ? 1'b1 :
                    (capture_enable_pulse ? 1'b0 : m_arm);
         m_pulse  = m_arm && !m_arm_r;
         m_arm_r  = m_arm;
         m_arm    = next_arm;
         m_cap_r  = m_cap;
         m_cap    = arm_wr && write_data[1];

         if (sel && reg_write) begin
            case (idx)
               REG_TRIGGER_ENABLE: m_en = write_data[0];
               REG_NUM_TRIGGERS:   m_num = write_data[3:0];
               REG_TRIGGER_DELAY:  if (lane < 3) m_delay[lane*8 +: 8] = write_data;
               REG_TRIGGER_WIDTH:  if (lane < 3) m_width[lane*8 +: 8] = write_data;
               REG_CAPTURE_LEN:    if (lane < 3) m_len[lane*8 +: 8] = write_data;
               default: ;
            endcase
         end
      end
   end

endmodule

// File: reg_main_top.sv
// Main register block top: bus decode, configuration registers and read path
`timescale 1ns/1ps
`include "main_reg_params.svh"

module reg_main_top
   import main_reg_pkg::*;
   import fifo_word_pkg::*;
(
   input  logic                          cwusb_clk,
   input  logic                          fpga_reset,
   // Host register bus
   input  logic [7:0]                    reg_address,
   input  logic [`MAIN_BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic                          reg_addrvalid,
   input  logic                          reg_read,
   input  logic                          reg_write,
   input  logic [7:0]                    write_data,
   output logic [7:0]                    read_data,
   // Sniff FIFO
   input  fifo_word_t                    fifo_data,
   input  fifo_status_t                  fifo_status,
   input  logic                          fifo_empty,
   output logic                          fifo_read,
   // Capture front end
   input  logic                          capture_enable_pulse,
   input  logic                          flushing,
   output logic                          arm,
   output logic                          reg_arm,
   output logic                          arm_pulse,
   output logic                          capture_now,
   output capture_len_t                  capture_len,
   // Trigger generator
   output logic                          trigger_enable,
   output trig_time_t                    trigger_delay,
   output trig_time_t                    trigger_width,
   output num_trig_t                     num_triggers
);

   logic       sel_read;
   logic       sel_write;
   logic       first_read;
   reg_addr_e  reg_index;
   logic [7:0] cfg_rdata;

   reg_decode u_reg_decode (
      .cwusb_clk     (cwusb_clk),
      .fpga_reset    (fpga_reset),
      .reg_address   (reg_address),
      .reg_addrvalid (reg_addrvalid),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .sel_read      (sel_read),
      .sel_write     (sel_write),
      .first_read    (first_read),
      .reg_index     (reg_index)
   );

   config_regs u_config_regs (
      .cwusb_clk            (cwusb_clk),
      .fpga_reset           (fpga_reset),
      .sel_write            (sel_write),
      .reg_index            (reg_index),
      .reg_bytecnt          (reg_bytecnt),
      .write_data           (write_data),
      .capture_enable_pulse (capture_enable_pulse),
      .flushing             (flushing),
      .arm                  (arm),
      .reg_arm              (reg_arm),
      .arm_pulse            (arm_pulse),
      .capture_now          (capture_now),
      .trigger_enable       (trigger_enable),
      .trigger_delay        (trigger_delay),
      .trigger_width        (trigger_width),
      .num_triggers         (num_triggers),
      .capture_len          (capture_len),
      .cfg_rdata            (cfg_rdata)
   );

   read_path u_read_path (
      .cwusb_clk   (cwusb_clk),
      .fpga_reset  (fpga_reset),
      .sel_read    (sel_read),
      .first_read  (first_read),
      .reg_index   (reg_index),
      .reg_bytecnt (reg_bytecnt),
      .cfg_rdata   (cfg_rdata),
      .fifo_data   (fifo_data),
      .fifo_status (fifo_status),
      .fifo_empty  (fifo_empty),
      .fifo_read   (fifo_read),
      .read_data   (read_data)
   );

endmodule

// File: tb_reg_main.sv
// Testbench top: clock, reset, DUT, sniff FIFO model and random host register transactions
`timescale 1ns/1ps
`include "main_reg_params.svh"

module tb_reg_main
   import main_reg_pkg::*;
   import fifo_word_pkg::*;
;

   localparam int WAIT_LIMIT = 20;

   logic                           cwusb_clk = 1'b0;
   logic                           fpga_reset;
   logic [7:0]                     reg_address;
   logic [`MAIN_BYTECNT_WIDTH-1:0] reg_bytecnt;
   logic                           reg_addrvalid;
   logic                           reg_read;
   logic                           reg_write;
   logic [7:0]                     write_data;
   logic [7:0]                     read_data;
   fifo_word_t                     fifo_data;
   fifo_status_t                   fifo_status;
   logic                           fifo_empty;
   logic                           fifo_read;
   logic                           capture_enable_pulse;
   logic                           flushing;
   logic                           arm;
   logic                           reg_arm;
   logic                           arm_pulse;
   logic                           capture_now;
   capture_len_t                   capture_len;
   logic                           trigger_enable;
   trig_time_t                     trigger_delay;
   trig_time_t                     trigger_width;
   num_trig_t                      num_triggers;

   logic [127:0] test_name;
   int           checks;
   int           value_errors;
   int           timeouts = 0;

   // FIFO model state
   fifo_word_t fifo_q[$];
   logic       push_valid;
   fifo_word_t push_data;

   // Config registers sit at index 3 and above
   reg_addr_e kept_regs[8] = '{REG_ARM, REG_FIFO_STAT, REG_FIFO_RD, REG_TRIGGER_ENABLE,
                               REG_NUM_TRIGGERS, REG_TRIGGER_DELAY, REG_TRIGGER_WIDTH,
                               REG_CAPTURE_LEN};

   always #2 cwusb_clk = ~cwusb_clk;

   reg_main_top dut_i (.*);

   reg_main_checker chk_i (.*);

   ///////////////////////////////
   // Sniff FIFO model
   ///////////////////////////////

   always @(posedge cwusb_clk) begin
      if (fifo_read && fifo_q.size() > 0)
         void'(fifo_q.pop_front());
      if (push_valid)
         fifo_q.push_back(push_data);
      fifo_empty <= (fifo_q.size() == 0);
      fifo_data  <= (fifo_q.size() > 0) ? fifo_q[0] : '0;
   end

   ///////////////////////////////
   // Host bus tasks
   ///////////////////////////////

   task automatic write_byte(input logic [7:0] addr, input logic [6:0] lane,
                             input logic [7:0] data, input logic valid);
      @(posedge cwusb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= lane;
      write_data    <= data;
      reg_addrvalid <= valid;
      reg_write     <= 1'b1;
      @(posedge cwusb_clk);
      reg_write     <= 1'b0;
      reg_addrvalid <= 1'b0;
   endtask

   // Lanes 0 to 3 in one burst
   task automatic read_burst(input logic [7:0] addr, input logic valid);
      int i;
      for (i = 0; i < 4; i++) begin
         @(posedge cwusb_clk);
         reg_address   <= addr;
         reg_addrvalid <= valid;
         reg_read      <= 1'b1;
         reg_bytecnt   <= 7'(i);
      end
      @(posedge cwusb_clk);
      reg_read      <= 1'b0;
      reg_addrvalid <= 1'b0;
   endtask

   task automatic read_all();
      int i;
      for (i = 0; i < 8; i++)
         read_burst({`MAIN_REG_SELECT, kept_regs[i]}, 1'b1);
   endtask

   task automatic push_word(input fifo_word_t w);
      @(posedge cwusb_clk);
      push_valid  <= 1'b1;
      push_data   <= w;
      fifo_status <= fifo_status_t'($urandom);
      @(posedge cwusb_clk);
      push_valid  <= 1'b0;
   endtask

   task automatic pulse_capture();
      @(posedge cwusb_clk);
      capture_enable_pulse <= 1'b1;
      @(posedge cwusb_clk);
      capture_enable_pulse <= 1'b0;
   endtask

   function automatic logic condition_met(input int which);
      case (which)
         0:       return arm_pulse;
         1:       return !reg_arm;
         default: return !fifo_empty;
      endcase
   endfunction

   // Sampled on the falling edge, away from the register updates
   task automatic wait_until(input int which, input string what);
      int cnt;
      cnt = 0;
      while (!condition_met(which) && cnt < WAIT_LIMIT) begin
         @(negedge cwusb_clk);
         cnt++;
      end
      if (!condition_met(which)) begin
         $display("Timeout while waiting for %0s", what);
         timeouts++;
      end
   endtask

   // First burst clears the empty marker, the rest pop one word each
   task automatic fifo_round(input int n);
      int i;
      for (i = 0; i < n; i++)
         push_word(fifo_word_t'($urandom));
      wait_until(2, "FIFO data");
      for (i = 0; i <= n; i++)
         read_burst({`MAIN_REG_SELECT, REG_FIFO_RD}, 1'b1);
   endtask

   ///////////////////////////////
   // Test sequence
   ///////////////////////////////

   initial begin
      reg_addr_e  r;
      logic [1:0] code;
      logic       valid;
      logic       now_bit;
      logic [7:0] arm_cmd;
      void'($urandom(43));
      fpga_reset           = 1'b1;
      reg_address          = '0;
      reg_bytecnt          = '0;
      reg_addrvalid        = 1'b0;
      reg_read             = 1'b0;
      reg_write            = 1'b0;
      write_data           = '0;
      fifo_data            = '0;
      fifo_status          = '0;
      fifo_empty           = 1'b1;
      capture_enable_pulse = 1'b0;
      flushing             = 1'b0;
      push_valid           = 1'b0;
      push_data            = '0;
      test_name            = "reset";
      repeat (3) @(posedge cwusb_clk);
      fpga_reset <= 1'b0;
      read_all();

      test_name = "config";
      repeat (60) begin
         r = kept_regs[3 + $urandom % 5];
         write_byte({`MAIN_REG_SELECT, r}, 7'($urandom % 4), 8'($urandom), 1'b1);
         if ($urandom % 3 == 0)
            read_burst({`MAIN_REG_SELECT, kept_regs[3 + $urandom % 5]}, 1'b1);
      end
      read_all();

      test_name = "arm";
      repeat (10) begin
         pulse_capture();
         wait_until(1, "reg_arm to clear");
         now_bit = 1'($urandom % 2);
         arm_cmd = {6'b0, now_bit, 1'b1};
         // Some rounds start a capture in the same cycle as the arming write
         if ($urandom % 2 == 0) begin
            fork
               write_byte({`MAIN_REG_SELECT, REG_ARM}, 7'd0, arm_cmd, 1'b1);
               pulse_capture();
            join
         end else begin
            write_byte({`MAIN_REG_SELECT, REG_ARM}, 7'd0, arm_cmd, 1'b1);
         end
         wait_until(0, "arm_pulse");
         repeat (8) begin
            @(posedge cwusb_clk);
            flushing             <= ($urandom % 3 == 0);
            capture_enable_pulse <= ($urandom % 4 == 0);
         end
         @(posedge cwusb_clk);
         flushing             <= 1'b0;
         capture_enable_pulse <= 1'b0;
         read_burst({`MAIN_REG_SELECT, REG_ARM}, 1'b1);
      end

      test_name = "fifo";
      fifo_round(6);

      test_name = "empty";
      read_burst({`MAIN_REG_SELECT, REG_FIFO_RD}, 1'b1);
      read_burst({`MAIN_REG_SELECT, REG_FIFO_RD}, 1'b1);
      fifo_round(3);

      test_name = "foreign";
      repeat (20) begin
         r     = kept_regs[$urandom % 8];
         code  = 2'($urandom % 4);
         valid = (code != `MAIN_REG_SELECT);
         write_byte({code, r}, 7'($urandom % 4), 8'($urandom), valid);
         read_burst({code, r}, valid);
      end
      read_all();

      repeat (4) @(posedge cwusb_clk);
      $display("Checks: %0d, value errors: %0d, timeouts: %0d, assertion failures: %0d",
               checks, value_errors, timeouts, dut_i.assert_i.failures);
      if (value_errors == 0 && timeouts == 0 && dut_i.assert_i.failures == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule
